// File: masked_arith_defines.svh
`ifndef MASKED_ARITH_DEFINES_SVH
`define MASKED_ARITH_DEFINES_SVH

// Data path width in bits, one masked full adder per bit except the top
`define MA_WIDTH 8

// Generator reset state, must be nonzero for xorshift
`define MA_RNG_SEED 32'h6d2b_79f5

`endif

// File: masked_share_pkg.sv
`include "masked_arith_defines.svh"

// ========================================
// Boolean share types
// ========================================
package masked_share_pkg;

    // One bit split into two XOR shares
    // True value is share1 ^ share0
    typedef struct packed {
        logic share1; // Upper domain
        logic share0; // Lower domain
    } share_bit_t;

    // Whole operand in shares, index 0 is the LSB
    typedef share_bit_t [`MA_WIDTH-1:0] share_word_t;

endpackage : masked_share_pkg

// File: masked_op_pkg.sv
// ========================================
// Request and response formats
// ========================================
package masked_op_pkg;

    // Operation select
    typedef enum logic {
        ADD = 1'b0, // x + y
        SUB = 1'b1  // x - y
    } op_e;

    typedef logic [3:0] tag_t; // Opaque request id, echoed back

    typedef struct packed {
        op_e                           op;
        tag_t                          tag;
        masked_share_pkg::share_word_t x; // Minuend or addend
        masked_share_pkg::share_word_t y; // Subtrahend or addend
    } addsub_req_t;

    typedef struct packed {
        tag_t                          tag;
        masked_share_pkg::share_word_t s; // Result, still masked
    } addsub_rsp_t;

endpackage : masked_op_pkg

// File: masked_full_adder.sv
`timescale 1ns/1ns

module masked_full_adder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         zeroize,
    input  masked_share_pkg::share_bit_t x,
    input  masked_share_pkg::share_bit_t y,
    input  masked_share_pkg::share_bit_t c_in,
    input  logic                         rnd,   // Fresh mask bit, new each cycle
    output masked_share_pkg::share_bit_t s,
    output masked_share_pkg::share_bit_t c_out
);

    masked_share_pkg::share_bit_t p; // Propagate term x ^ y
    logic inner0; // Domain 0 own products
    logic inner1; // Domain 1 own products
    logic cross0; // Cross products landing in domain 0
    logic cross1; // Cross products landing in domain 1

    assign p = x ^ y; // Linear, done per share

    // Carry = x&y ^ c&p, both AND terms split by domain
    assign inner0 = (x.share0 & y.share0) ^ (c_in.share0 & p.share0);
    assign inner1 = (x.share1 & y.share1) ^ (c_in.share1 & p.share1);

    // Same rnd in both domains, cancels on unmasking
    assign cross0 = (x.share0 & y.share1) ^ (c_in.share0 & p.share1) ^ rnd;
    assign cross1 = (x.share1 & y.share0) ^ (c_in.share1 & p.share0) ^ rnd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s     <= '0;
            c_out <= '0;
        end else if (zeroize) begin
            s     <= '0; // Wipe secret shares
            c_out <= '0;
        end else begin
            s            <= p ^ c_in;
            c_out.share0 <= inner0 ^ cross0;
            c_out.share1 <= inner1 ^ cross1;
        end
    end

    // Zeroize must reach both output registers
    a_zeroize_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        zeroize |=> (s == '0 && c_out == '0)
    );

endmodule : masked_full_adder

// File: masked_bool_addsub.sv
`timescale 1ns/1ns
`include "masked_arith_defines.svh"

module masked_bool_addsub (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,
    input  logic                          sub,    // Carry-in of one for x + ~y + 1
    input  masked_share_pkg::share_word_t x,
    input  masked_share_pkg::share_word_t y,
    input  logic [`MA_WIDTH-1:0]          rnd,
    output masked_share_pkg::share_word_t s
);

    localparam int unsigned W = `MA_WIDTH;

    masked_share_pkg::share_bit_t [W-1:0] carry; // carry[i] enters bit i
    logic                                 sub_q; // Aligned with skew stage 0

    // ========================================
    // Carry-in
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sub_q <= 1'b0;
        end else if (zeroize) begin
            sub_q <= 1'b0;
        end else begin
            sub_q <= sub;
        end
    end

    // Public constant one, carried in share0 only
    assign carry[0].share1 = 1'b0;
    assign carry[0].share0 = sub_q;

    // ========================================
    // Per-bit skew, add and deskew
    // ========================================
    for (genvar i = 0; i < W; i++) begin : g_bit
        masked_share_pkg::share_bit_t [i:0]     x_skew;  // i+1 stages
        masked_share_pkg::share_bit_t [i:0]     y_skew;
        masked_share_pkg::share_bit_t           sum_raw; // Registered sum of bit i
        masked_share_pkg::share_bit_t [W-1-i:0] sum_dly; // W-i stages

        // Bit i waits until carry from bit i-1 is ready
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                x_skew <= '0;
                y_skew <= '0;
            end else if (zeroize) begin
                x_skew <= '0;
                y_skew <= '0;
            end else begin
                x_skew[0] <= x[i];
                y_skew[0] <= y[i];
                for (int j = 1; j <= i; j++) begin
                    x_skew[j] <= x_skew[j-1];
                    y_skew[j] <= y_skew[j-1];
                end
            end
        end

        if (i < W-1) begin : g_fa
            masked_full_adder u_fa (
                .clk     (clk),
                .rst_n   (rst_n),
                .zeroize (zeroize),
                .x       (x_skew[i]),
                .y       (y_skew[i]),
                .c_in    (carry[i]),
                .rnd     (rnd[i]),
                .s       (sum_raw),
                .c_out   (carry[i+1])
            );
        end else begin : g_top
            // No carry out needed, spare rnd bit refreshes the shares
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    sum_raw <= '0;
                end else if (zeroize) begin
                    sum_raw <= '0;
                end else begin
                    sum_raw <= x_skew[i] ^ y_skew[i] ^ carry[i] ^ {2{rnd[i]}};
                end
            end
        end

        // Low bits finish early and wait here for the top bit
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sum_dly <= '0;
            end else if (zeroize) begin
                sum_dly <= '0;
            end else begin
                sum_dly[0] <= sum_raw;
                for (int j = 1; j <= W-1-i; j++) begin
                    sum_dly[j] <= sum_dly[j-1];
                end
            end
        end

        assign s[i] = sum_dly[W-1-i]; // All bits leave together
    end

endmodule : masked_bool_addsub

// File: masked_addsub_ctrl.sv
`timescale 1ns/1ns
`include "masked_arith_defines.svh"

module masked_addsub_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,
    input  logic                          req_valid,
    input  masked_op_pkg::addsub_req_t    req,
    input  masked_share_pkg::share_word_t s,      // Result from the adder
    output masked_share_pkg::share_word_t x,
    output masked_share_pkg::share_word_t y,
    output logic                          sub,
    output logic                          rsp_valid,
    output masked_op_pkg::addsub_rsp_t    rsp
);

    localparam int unsigned DLY = `MA_WIDTH + 2; // Matches adder latency

    logic                                  is_sub;
    masked_share_pkg::share_word_t         y_in;      // y, inverted for SUB
    logic                                  valid_q;
    masked_op_pkg::tag_t                   tag_q;
    logic [DLY-1:0]                        valid_dly;
    masked_op_pkg::tag_t [DLY-1:0]         tag_dly;

    assign is_sub = (req.op == masked_op_pkg::SUB);

    // Flipping one share flips the true value
    always_comb begin
        for (int i = 0; i < `MA_WIDTH; i++) begin
            y_in[i].share1 = req.y[i].share1;
            y_in[i].share0 = req.y[i].share0 ^ is_sub;
        end
    end

    // ========================================
    // Input register and valid line
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x         <= '0;
            y         <= '0;
            sub       <= 1'b0;
            valid_q   <= 1'b0;
            valid_dly <= '0;
        end else if (zeroize) begin
            x         <= '0; // Drops everything in flight
            y         <= '0;
            sub       <= 1'b0;
            valid_q   <= 1'b0;
            valid_dly <= '0;
        end else begin
            x         <= req.x;
            y         <= y_in;
            sub       <= is_sub;
            valid_q   <= req_valid;
            valid_dly <= {valid_dly[DLY-2:0], valid_q};
        end
    end

    // Tag is public, only follows the valid line
    always_ff @(posedge clk) begin
        tag_q   <= req.tag;
        tag_dly <= {tag_dly[DLY-2:0], tag_q};
    end

    assign rsp_valid = valid_dly[DLY-1];

    always_comb begin
        rsp.tag = tag_dly[DLY-1];
        rsp.s   = s; // Still masked
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(rsp_valid)
    );

    a_zeroize_kills_rsp: assert property (
        @(posedge clk) disable iff (!rst_n) zeroize |=> !rsp_valid
    );

endmodule : masked_addsub_ctrl

// File: masked_rng.sv
`timescale 1ns/1ns
`include "masked_arith_defines.svh"

module masked_rng (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 zeroize,
    output logic [`MA_WIDTH-1:0] rnd     // One bit per adder stage
);

    logic [31:0] state;
    logic [31:0] step_a; // After << 13
    logic [31:0] step_b; // After >> 17
    logic [31:0] nxt;    // After << 5

    // Xorshift32 step, bijective so zero is never reached
    always_comb begin
        step_a = state ^ (state << 13);
        step_b = step_a ^ (step_a >> 17);
        nxt    = step_b ^ (step_b << 5);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= `MA_RNG_SEED;
        end else if (zeroize) begin
            state <= `MA_RNG_SEED; // Restart sequence
        end else begin
            state <= nxt;
        end
    end

    assign rnd = state[`MA_WIDTH-1:0];

    // A zero state would lock the generator
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) state != '0
    );

endmodule : masked_rng

// File: masked_arith_top.sv
`timescale 1ns/1ns
`include "masked_arith_defines.svh"

module masked_arith_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       zeroize,
    input  logic                       req_valid,
    input  masked_op_pkg::addsub_req_t req,
    output logic                       rsp_valid,
    output masked_op_pkg::addsub_rsp_t rsp
);

    masked_share_pkg::share_word_t x;   // Registered operands
    masked_share_pkg::share_word_t y;
    masked_share_pkg::share_word_t s;   // Adder result
    logic                          sub;
    logic [`MA_WIDTH-1:0]          rnd;

    masked_addsub_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .req_valid (req_valid),
        .req       (req),
        .s         (s),
        .x         (x),
        .y         (y),
        .sub       (sub),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    masked_rng u_rng (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .rnd     (rnd)
    );

    masked_bool_addsub u_addsub (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .sub     (sub),
        .x       (x),
        .y       (y),
        .rnd     (rnd),
        .s       (s)
    );

endmodule : masked_arith_top

// File: masked_arith_checker.sv
`timescale 1ns/1ns
`include "masked_arith_defines.svh"

module masked_arith_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       zeroize,
    input  logic                       req_valid,
    input  masked_op_pkg::addsub_req_t req,
    input  logic [`MA_WIDTH-1:0]       exp_s,         // Expected sum from the data file
    input  logic                       rsp_valid,
    input  masked_op_pkg::addsub_rsp_t rsp,
    output int unsigned                checked,       // Responses matched to a request
    output int unsigned                value_errors,
    output int unsigned                tag_errors,
    output int unsigned                timing_errors, // Late, early, missing or stray
    output int unsigned                pending        // Requests still in flight
);

    localparam int unsigned LATENCY = `MA_WIDTH + 3; // Edges from request to response

    // One outstanding request
    typedef struct packed {
        logic [31:0]          due;   // Edge at which rsp_valid must be seen
        masked_op_pkg::tag_t  tag;
        logic [`MA_WIDTH-1:0] value; // Unmasked expected result
    } expect_t;

    expect_t     exp_q[$]; // Oldest first
    int unsigned cycle;

    // True bit is the XOR of both shares
    function automatic logic [`MA_WIDTH-1:0] unmask(input masked_share_pkg::share_word_t w);
        logic [`MA_WIDTH-1:0] v;
        for (int i = 0; i < `MA_WIDTH; i++) begin
            v[i] = w[i].share1 ^ w[i].share0;
        end
        return v;
    endfunction

    initial begin
        checked       = 0;
        value_errors  = 0;
        tag_errors    = 0;
        timing_errors = 0;
        pending       = 0;
        cycle         = 0;
    end

    // ========================================
    // Compare at every rising edge
    // ========================================
    always @(posedge clk) begin
        expect_t head;
        if (!rst_n) begin
            exp_q.delete();
            cycle = 0;
        end else begin
            cycle++;
            if ($isunknown(rsp_valid)) begin
                timing_errors++;
                $display("rsp_valid is unknown at cycle %0d", cycle);
            end
            if (rsp_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    timing_errors++;
                    $display("Response with tag %h came at cycle %0d with no request in flight",
                             rsp.tag, cycle);
                end else begin
                    head = exp_q.pop_front();
                    checked++;
                    if (head.due != cycle) begin
                        timing_errors++;
                        $display("Response for tag %h came at cycle %0d, it was due at %0d",
                                 head.tag, cycle, head.due);
                    end
                    if (unmask(rsp.s) !== head.value) begin
                        value_errors++;
                        $display("CHECK FAILED rsp.s: got %h expected %h (tag %h)",
                                 unmask(rsp.s), head.value, head.tag);
                    end
                    if (rsp.tag !== head.tag) begin
                        tag_errors++;
                        $display("CHECK FAILED rsp.tag: got %h expected %h",
                                 rsp.tag, head.tag);
                    end
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                head = exp_q.pop_front(); // Due now but never showed up
                timing_errors++;
                $display("No response for tag %h, it was due at cycle %0d", head.tag, head.due);
            end

            if (zeroize) begin
                exp_q.delete(); // Drops everything in flight including this request
            end else if (req_valid) begin
                head.due   = cycle + LATENCY;
                head.tag   = req.tag;
                head.value = exp_s;
                exp_q.push_back(head);
            end
        end
        pending = exp_q.size();
    end

endmodule : masked_arith_checker

// File: masked_arith_tb.sv
`timescale 1ns/1ns
`include "masked_arith_defines.svh"

module masked_arith_tb;

    localparam int unsigned W          = `MA_WIDTH;
    localparam int unsigned FIELDS     = 6;  // op tag x y expected zeroize
    localparam int unsigned MAX_LINES  = 64;
    localparam int unsigned RST_CYCLES = 5;
    localparam int unsigned MARGIN     = 20; // Slack on top of the worst case run
    localparam logic [31:0] EMPTY      = 32'hdead_beef; // Marks entries the file left alone

    logic                       clk;
    logic                       rst_n;
    logic                       zeroize;
    logic                       req_valid;
    masked_op_pkg::addsub_req_t req;
    logic                       rsp_valid;
    masked_op_pkg::addsub_rsp_t rsp;
    logic [W-1:0]               exp_s; // Goes to the checker only

    logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
    logic [31:0] rng_state;
    int unsigned n_lines;
    int unsigned cycle_count;
    int unsigned cycle_limit;
    int unsigned load_errors;
    int unsigned checked;
    int unsigned value_errors;
    int unsigned tag_errors;
    int unsigned timing_errors;
    int unsigned pending;

    always #2 clk = ~clk; // 4 ns period

    masked_arith_top masked_arith_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize   (zeroize),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    masked_arith_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .zeroize       (zeroize),
        .req_valid     (req_valid),
        .req           (req),
        .exp_s         (exp_s),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .checked       (checked),
        .value_errors  (value_errors),
        .tag_errors    (tag_errors),
        .timing_errors (timing_errors),
        .pending       (pending)
    );

    // ========================================
    // Masking of operands
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    // share0 is random and share1 holds value ^ share0
    task automatic split_shares(input logic [W-1:0] value,
                                output masked_share_pkg::share_word_t word);
        logic [W-1:0] mask;
        rng_state = xorshift32(rng_state);
        mask      = rng_state[31 -: W]; // Upper bits mix best
        for (int i = 0; i < W; i++) begin
            word[i].share0 = mask[i];
            word[i].share1 = value[i] ^ mask[i];
        end
    endtask

    // Puts one line of the data file on the DUT inputs
    task automatic drive_line(input int unsigned k);
        masked_share_pkg::share_word_t xs;
        masked_share_pkg::share_word_t ys;
        split_shares(stim_mem[FIELDS*k+2][W-1:0], xs);
        split_shares(stim_mem[FIELDS*k+3][W-1:0], ys);
        req.op    = masked_op_pkg::op_e'(stim_mem[FIELDS*k][0]);
        req.tag   = stim_mem[FIELDS*k+1][3:0];
        req.x     = xs;
        req.y     = ys;
        exp_s     = stim_mem[FIELDS*k+4][W-1:0];
        zeroize   = stim_mem[FIELDS*k+5][0]; // Request on this line is dropped too
        req_valid = 1'b1;
    endtask

    // Hard stop sized from the data file
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout at cycle %0d with %0d responses still expected",
                     cycle_count, pending);
            $display("Something failed");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        zeroize     = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        exp_s       = '0;
        rng_state   = 32'd12090;
        load_errors = 0;
        cycle_count = 0;
        n_lines     = 0;
        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            stim_mem[i] = EMPTY;
        end
        $readmemh("masked_arith_testdata.txt", stim_mem);
        while (n_lines < MAX_LINES && stim_mem[FIELDS*n_lines] != EMPTY) begin
            n_lines++;
        end
        cycle_limit = RST_CYCLES + n_lines + 2*(W+3) + MARGIN; // Feed, drain, stray window

        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        if (n_lines == 0) begin
            load_errors++;
            $display("No stimulus lines could be read from masked_arith_testdata.txt");
        end else begin
            for (int k = 0; k < n_lines; k++) begin
                @(posedge clk);
                #1 drive_line(k); // One line per cycle back to back
            end
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            zeroize   = 1'b0;
            do begin
                @(posedge clk);
                #1;
            end while (pending != 0);
            repeat (W+3) @(posedge clk); // Window for stray responses
        end

        $display("Done: %0d responses, errors %0d value %0d tag %0d timing %0d load",
                 checked, value_errors, tag_errors, timing_errors, load_errors);
        if (value_errors + tag_errors + timing_errors + load_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : masked_arith_tb

// File: masked_arith.f
+incdir+.
masked_share_pkg.sv
masked_op_pkg.sv
masked_full_adder.sv
masked_bool_addsub.sv
masked_addsub_ctrl.sv
masked_rng.sv
masked_arith_top.sv
masked_arith_checker.sv
masked_arith_tb.sv

// File: Bender.yml
package:
  name: masked_arith

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - masked_share_pkg.sv
      - masked_op_pkg.sv
      - masked_full_adder.sv
      - masked_bool_addsub.sv
      - masked_addsub_ctrl.sv
      - masked_rng.sv
      - masked_arith_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - masked_arith_checker.sv
      - masked_arith_tb.sv

// File: masked_arith_testdata.txt
// Columns in hex: op tag x y expected zeroize, one request per line
// op 0 is add and 1 is sub, zeroize 1 also drops the request on that line
0 1 12 34 46 0
1 2 05 09 FC 0
0 3 FF 01 00 0
0 4 11 22 33 1
0 5 12 34 46 0
0 6 FF 01 00 0
0 7 80 80 00 0
0 8 7F 01 80 0
0 9 A5 5A FF 0
1 A 50 20 30 0
1 B 05 09 FC 0
1 C 3C 3C 00 0
1 D 00 01 FF 0
1 E 00 80 80 0
0 F 5A C3 1D 0
0 0 5A C3 1D 0
0 1 5A C3 1D 0
1 2 C8 64 64 0
1 3 C8 64 64 0
0 4 99 77 10 0
0 5 FF FF FE 0
1 6 FF 00 FF 0
